// ==== Bender.yml ====
package:
  name: mips_pipeline

export_include_dirs:
  - common

sources:
  - common/cpu_types_pkg.sv
  - datapath/register_file.sv
  - datapath/alu.sv
  - datapath/control_unit.sv
  - datapath/hazard_unit.sv
  - datapath/datapath.sv
  - src/memory_arbiter.sv
  - src/cpu.sv
  - target: simulation
    files:
      - tests/tb_cpu.sv

// ==== common/cpu_defs.svh ====
// ################################################
// width, register count and reset pc macros
// ################################################
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data word and address width.
`define WORD_W 32

// number of general purpose registers.
`define REG_COUNT 32

// first fetch address after reset.
`define PC_INIT 32'h0000_0000

`endif

// ==== common/cpu_types_pkg.sv ====
// ################################################
// word, register index, decode and arbiter types
// ################################################
`default_nettype none

`include "cpu_defs.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [4:0]         regbits_t;

  // mips primary opcodes.
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type function field.
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASSB
  } aluop_t;

  typedef enum logic [1:0] {
    PCSRC_PC4, PCSRC_BEQ, PCSRC_BNE, PCSRC_JUMP
  } pcsrc_t;

  typedef enum logic [1:0] {
    IDLE, IREQ, DREQ, RELEASE
  } arb_state_t;

endpackage

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/cpu_types_pkg.sv
datapath/register_file.sv
datapath/alu.sv
datapath/control_unit.sv
datapath/hazard_unit.sv
datapath/datapath.sv
src/memory_arbiter.sv
src/cpu.sv
tests/tb_cpu.sv

// ==== datapath/alu.sv ====
// ################################################
// 32-bit alu with zero flag
// ################################################
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_types_pkg::aluop_t aluop,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  port_o,
  output logic                  zero
);
  import cpu_types_pkg::*;

  always_comb begin
    case (aluop)
      ALU_ADD:   port_o = port_a + port_b;
      ALU_SUB:   port_o = port_a - port_b;
      ALU_AND:   port_o = port_a & port_b;
      ALU_OR:    port_o = port_a | port_b;
      ALU_XOR:   port_o = port_a ^ port_b;
      // signed compare.
      ALU_SLT:   port_o = word_t'($signed(port_a) < $signed(port_b));
      ALU_PASSB: port_o = port_b;
      default:   port_o = '0;
    endcase
  end

  assign zero = (port_o == '0);

endmodule

`default_nettype wire

// ==== datapath/control_unit.sv ====
// ################################################
// opcode and funct decode into stage controls
// ################################################
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  cpu_types_pkg::opcode_t opcode,
  input  cpu_types_pkg::funct_t  funct,
  output cpu_types_pkg::aluop_t  aluop,
  output logic                   alusrc_imm,
  output logic                   extsel_signed,
  output logic                   regdst_rt,
  output logic                   regwen,
  output logic                   dren,
  output logic                   dwen,
  output cpu_types_pkg::pcsrc_t  pcsrc,
  output logic                   is_halt
);
  import cpu_types_pkg::*;

  always_comb begin
    // anything not listed below is a no-op.
    aluop         = ALU_ADD;
    alusrc_imm    = 1'b0;
    extsel_signed = 1'b0;
    regdst_rt     = 1'b0;
    regwen        = 1'b0;
    dren          = 1'b0;
    dwen          = 1'b0;
    pcsrc         = PCSRC_PC4;
    is_halt       = 1'b0;
    case (opcode)
      RTYPE: begin
        regwen = 1'b1;
        case (funct)
          ADDU:    aluop = ALU_ADD;
          SUBU:    aluop = ALU_SUB;
          AND:     aluop = ALU_AND;
          OR:      aluop = ALU_OR;
          XOR:     aluop = ALU_XOR;
          SLT:     aluop = ALU_SLT;
          default: regwen = 1'b0;
        endcase
      end
      ADDIU, LW, SW: begin
        alusrc_imm    = 1'b1;
        extsel_signed = 1'b1;
        regdst_rt     = 1'b1;
        regwen        = (opcode != SW);
        dren          = (opcode == LW);
        dwen          = (opcode == SW);
      end
      ORI, LUI: begin
        aluop      = (opcode == LUI) ? ALU_PASSB : ALU_OR;
        alusrc_imm = 1'b1;
        regdst_rt  = 1'b1;
        regwen     = 1'b1;
      end
      BEQ, BNE: begin
        // compare by subtraction, zero flag decides.
        aluop         = ALU_SUB;
        extsel_signed = 1'b1;
        pcsrc         = (opcode == BEQ) ? PCSRC_BEQ : PCSRC_BNE;
      end
      J:       pcsrc = PCSRC_JUMP;
      HALT:    is_halt = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== datapath/datapath.sv ====
// ################################################
// fetch, execute and writeback stages with pc,
// pipeline registers, forwarding and halt latch
// ################################################
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module datapath (
  input  logic                 CLK,
  input  logic                 nRST,
  output logic                 i_req,
  output cpu_types_pkg::word_t i_addr,
  input  logic                 i_done,
  input  cpu_types_pkg::word_t i_rdata,
  output logic                 d_req,
  output logic                 d_wen,
  output cpu_types_pkg::word_t d_addr,
  output cpu_types_pkg::word_t d_wdata,
  input  logic                 d_done,
  input  cpu_types_pkg::word_t d_rdata,
  output logic                 halt
);
  import cpu_types_pkg::*;

  word_t    pc, pc4, npc, fetch_word, i_held, d_held, load_data;
  logic     running, i_sat, d_sat, advance, halted, step, flush, fwd_a, fwd_b;
  word_t    fe_instr, fe_pc4;
  opcode_t  ex_opcode;
  regbits_t ex_rs, ex_rt, ex_rd;
  word_t    ex_imm_sext, ex_imm, rdat1, rdat2, op_a, op_b, alu_b, alu_out;
  word_t    br_target, j_target;
  logic     alu_zero;
  aluop_t   ex_aluop;
  pcsrc_t   ex_pcsrc;
  logic     ex_alusrc_imm, ex_signed, ex_regdst_rt, ex_regwen, ex_dren, ex_dwen, ex_halt;
  word_t    wb_alu, wb_store, wb_data;
  regbits_t wb_rsel;
  logic     wb_regwen, wb_dren, wb_dwen, wb_halt;

  // fetch stage.
  assign pc4        = pc + 32'd4;
  assign fetch_word = i_done ? i_rdata : i_held;
  assign i_addr     = pc;
  assign i_req      = running && !halted && !i_sat && !i_done;

  // all stages move together once both channels are satisfied.
  assign advance = (i_done || i_sat) && (!(wb_dren || wb_dwen) || d_done || d_sat);
  assign halted  = halt || wb_halt;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc       <= `PC_INIT;
      fe_instr <= '0;
    end else if (step) begin
      pc       <= npc;
      fe_instr <= flush ? '0 : fetch_word;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      running <= 1'b0;
      halt    <= 1'b0;
      i_sat   <= 1'b0;
      d_sat   <= 1'b0;
    end else begin
      running <= 1'b1;
      halt    <= halt | wb_halt;
      if (step) begin
        i_sat <= 1'b0;
        d_sat <= 1'b0;
      end else begin
        if (i_done) i_sat <= 1'b1;
        if (d_done) d_sat <= 1'b1;
      end
    end
  end

  // completed results kept while the other channel finishes.
  always_ff @(posedge CLK) begin
    if (i_done) i_held <= i_rdata;
    if (d_done) d_held <= d_rdata;
    if (step)   fe_pc4 <= pc4;
  end

  // execute stage.
  assign ex_opcode   = opcode_t'(fe_instr[31:26]);
  assign ex_rs       = fe_instr[25:21];
  assign ex_rt       = fe_instr[20:16];
  assign ex_rd       = fe_instr[15:11];
  assign ex_imm_sext = {{16{fe_instr[15]}}, fe_instr[15:0]};
  assign ex_imm      = (ex_opcode == LUI) ? {fe_instr[15:0], 16'h0000} :
                       ex_signed          ? ex_imm_sext : {16'h0000, fe_instr[15:0]};

  assign op_a  = fwd_a ? wb_data : rdat1;
  assign op_b  = fwd_b ? wb_data : rdat2;
  assign alu_b = ex_alusrc_imm ? ex_imm : op_b;

  assign br_target = fe_pc4 + {ex_imm_sext[29:0], 2'b00};
  assign j_target  = {fe_pc4[31:28], fe_instr[25:0], 2'b00};
  assign npc       = !flush ? pc4 : (ex_pcsrc == PCSRC_JUMP) ? j_target : br_target;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_regwen <= 1'b0;
      wb_dren   <= 1'b0;
      wb_dwen   <= 1'b0;
      wb_halt   <= 1'b0;
      wb_rsel   <= '0;
    end else if (step) begin
      wb_regwen <= ex_regwen;
      wb_dren   <= ex_dren;
      wb_dwen   <= ex_dwen;
      wb_halt   <= ex_halt;
      wb_rsel   <= ex_regdst_rt ? ex_rt : ex_rd;
    end
  end

  always_ff @(posedge CLK) begin
    if (step) begin
      wb_alu   <= alu_out;
      wb_store <= op_b;
    end
  end

  // writeback stage, register write lands on the advancing edge.
  assign load_data = d_done ? d_rdata : d_held;
  assign wb_data   = wb_dren ? load_data : wb_alu;
  assign d_req     = (wb_dren || wb_dwen) && !d_sat && !d_done && !halt;
  assign d_wen     = wb_dwen;
  assign d_addr    = wb_alu;
  assign d_wdata   = wb_store;

  register_file rf_i (
    .CLK(CLK), .nRST(nRST), .wen(wb_regwen && step), .wsel(wb_rsel), .wdat(wb_data),
    .rsel1(ex_rs), .rsel2(ex_rt), .rdat1(rdat1), .rdat2(rdat2)
  );

  alu alu_i (
    .aluop(ex_aluop), .port_a(op_a), .port_b(alu_b), .port_o(alu_out), .zero(alu_zero)
  );

  control_unit cu_i (
    .opcode(ex_opcode), .funct(funct_t'(fe_instr[5:0])), .aluop(ex_aluop),
    .alusrc_imm(ex_alusrc_imm), .extsel_signed(ex_signed), .regdst_rt(ex_regdst_rt),
    .regwen(ex_regwen), .dren(ex_dren), .dwen(ex_dwen), .pcsrc(ex_pcsrc),
    .is_halt(ex_halt)
  );

  hazard_unit hu_i (
    .ex_rs(ex_rs), .ex_rt(ex_rt), .wb_regwen(wb_regwen), .wb_rsel(wb_rsel),
    .ex_pcsrc(ex_pcsrc), .ex_zero(alu_zero), .advance(advance), .halted(halted),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .flush(flush), .step(step)
  );

endmodule

`default_nettype wire

// ==== datapath/hazard_unit.sv ====
// ################################################
// forwarding select, branch flush, pipeline step
// ################################################
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_types_pkg::regbits_t ex_rs,
  input  cpu_types_pkg::regbits_t ex_rt,
  input  logic                    wb_regwen,
  input  cpu_types_pkg::regbits_t wb_rsel,
  input  cpu_types_pkg::pcsrc_t   ex_pcsrc,
  input  logic                    ex_zero,
  input  logic                    advance,
  input  logic                    halted,
  output logic                    fwd_a,
  output logic                    fwd_b,
  output logic                    flush,
  output logic                    step
);
  import cpu_types_pkg::*;

  // only writeback can be ahead of execute.
  assign fwd_a = wb_regwen && wb_rsel != '0 && wb_rsel == ex_rs;
  assign fwd_b = wb_regwen && wb_rsel != '0 && wb_rsel == ex_rt;

  assign flush = (ex_pcsrc == PCSRC_JUMP) ||
                 (ex_pcsrc == PCSRC_BEQ && ex_zero) ||
                 (ex_pcsrc == PCSRC_BNE && !ex_zero);

  assign step = advance && !halted;

endmodule

`default_nettype wire

// ==== datapath/register_file.sv ====
// ################################################
// 32 x 32-bit register file, r0 reads zero
// ################################################
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  word_t regs [`REG_COUNT];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // r0 is never written, but force zero on read too.
  assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
// ################################################
// cpu top, datapath and memory arbiter
// ################################################
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic                 CLK,
  input  logic                 nRST,
  output logic                 mem_req,
  output logic                 mem_wen,
  output cpu_types_pkg::word_t mem_addr,
  output cpu_types_pkg::word_t mem_wdata,
  input  logic                 mem_ack,
  input  cpu_types_pkg::word_t mem_rdata,
  output logic                 halt
);
  import cpu_types_pkg::*;

  logic  i_req, i_done, d_req, d_wen, d_done;
  word_t i_addr, i_rdata, d_addr, d_wdata, d_rdata;

  datapath dp_i (
    .CLK(CLK), .nRST(nRST),
    .i_req(i_req), .i_addr(i_addr), .i_done(i_done), .i_rdata(i_rdata),
    .d_req(d_req), .d_wen(d_wen), .d_addr(d_addr), .d_wdata(d_wdata),
    .d_done(d_done), .d_rdata(d_rdata), .halt(halt)
  );

  memory_arbiter arb_i (
    .CLK(CLK), .nRST(nRST),
    .i_req(i_req), .i_addr(i_addr), .i_done(i_done), .i_rdata(i_rdata),
    .d_req(d_req), .d_wen(d_wen), .d_addr(d_addr), .d_wdata(d_wdata),
    .d_done(d_done), .d_rdata(d_rdata),
    .mem_req(mem_req), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata)
  );

endmodule

`default_nettype wire

// ==== src/memory_arbiter.sv ====
// ################################################
// fetch/data arbiter onto a four-phase memory port
// ################################################
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 i_req,
  input  cpu_types_pkg::word_t i_addr,
  output logic                 i_done,
  output cpu_types_pkg::word_t i_rdata,
  input  logic                 d_req,
  input  logic                 d_wen,
  input  cpu_types_pkg::word_t d_addr,
  input  cpu_types_pkg::word_t d_wdata,
  output logic                 d_done,
  output cpu_types_pkg::word_t d_rdata,
  output logic                 mem_req,
  output logic                 mem_wen,
  output cpu_types_pkg::word_t mem_addr,
  output cpu_types_pkg::word_t mem_wdata,
  input  logic                 mem_ack,
  input  cpu_types_pkg::word_t mem_rdata
);
  import cpu_types_pkg::*;

  arb_state_t state;
  logic       sel_d;
  word_t      rdata_q;

  assign i_rdata = rdata_q;
  assign d_rdata = rdata_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      sel_d     <= 1'b0;
      mem_req   <= 1'b0;
      mem_wen   <= 1'b0;
      mem_addr  <= '0;
      mem_wdata <= '0;
      rdata_q   <= '0;
      i_done    <= 1'b0;
      d_done    <= 1'b0;
    end else begin
      i_done <= 1'b0;
      d_done <= 1'b0;
      case (state)
        // data first, it belongs to the older instruction.
        IDLE: begin
          if (d_req && !d_done) begin
            state     <= DREQ;
            sel_d     <= 1'b1;
            mem_req   <= 1'b1;
            mem_wen   <= d_wen;
            mem_addr  <= d_addr;
            mem_wdata <= d_wdata;
          end else if (i_req && !i_done) begin
            state    <= IREQ;
            sel_d    <= 1'b0;
            mem_req  <= 1'b1;
            mem_wen  <= 1'b0;
            mem_addr <= i_addr;
          end
        end
        IREQ, DREQ: begin
          if (mem_ack) begin
            rdata_q <= mem_rdata;
            mem_req <= 1'b0;
            state   <= RELEASE;
          end
        end
        // wait for ack to fall before reporting completion.
        RELEASE: begin
          if (!mem_ack) begin
            state  <= IDLE;
            d_done <= sel_d;
            i_done <= !sel_d;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_cpu.sv ====
// ################################################
// cpu testbench with memory responder, random
// program generator and instruction-set model
// ################################################
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;

  localparam int MEM_WORDS   = 256;
  localparam int BODY_LEN    = 40;
  localparam int MAX_INSTR   = 60;
  localparam int CYCLE_LIMIT = MAX_INSTR * 2 * 10;
  localparam int BASE_IDX    = `PC_INIT >> 2;
  localparam logic [31:0] DATA_BASE = 32'h0000_0300;
  localparam logic [31:0] DUMP_BASE = 32'h0000_03e0;
  localparam logic [5:0] FUNCTS [6] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};
  localparam int T_HS   = 0;
  localparam int T_ST   = 1;
  localparam int T_MEM  = 2;
  localparam int T_HALT = 3;
  localparam int T_RST  = 4;

  logic CLK;
  logic nRST;
  logic mem_req, mem_wen, halt;
  logic mem_ack = 1'b0;
  logic [`WORD_W-1:0] mem_addr, mem_wdata;
  logic [`WORD_W-1:0] mem_rdata = '0;

  logic [15:0] lfsr = 16'd63;
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] model_mem [MEM_WORDS];
  logic [31:0] st_addr_q [$];
  logic [31:0] st_data_q [$];
  string names [5] = '{"handshake protocol", "store stream", "loads and control flow",
                       "halt", "reset state"};
  int errors [5] = '{0, 0, 0, 0, 0};
  int cycles = 0;
  int stores_seen = 0;
  int model_stores = 0;
  int ack_delay = 0;
  int passed;
  logic pending = 1'b0;
  logic released = 1'b0;
  logic prev_req = 1'b0;
  logic halt_seen = 1'b0;
  logic first_req_seen = 1'b0;
  logic [31:0] held_addr = '0;
  logic [31:0] held_wdata = '0;

  cpu cpu_i (
    .CLK(CLK), .nRST(nRST),
    .mem_req(mem_req), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .halt(halt)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) cycles <= cycles + 1;

  // 16-bit fibonacci lfsr, taps 16 14 13 11.
  function automatic logic [31:0] rnd_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [4:0] rnd_reg();
    return 5'(rnd_bits(3) % 7 + 1);
  endfunction

  task automatic report_value(input int t, input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s expected %h actual %h", names[t], exp, act);
    errors[t]++;
  endtask

  task automatic report_text(input int t, input string msg);
    $display("error in %s: %s", names[t], msg);
    errors[t]++;
  endtask

  task automatic gen_program();
    logic [3:0]  kind;
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm, dimm;
    logic [31:0] ins;
    int          skip;
    for (int a = 0; a < MEM_WORDS; a++) begin
      // fill pattern built from every address bit.
      mem[a] = {8'(a), ~8'(a), 8'(a) ^ 8'h5a, 8'(a * 37)};
    end
    for (int i = 0; i < BODY_LEN; i++) begin
      kind = 4'(rnd_bits(4));
      rs   = rnd_reg();
      rt   = rnd_reg();
      rd   = rnd_reg();
      imm  = 16'(rnd_bits(16));
      dimm = 16'(DATA_BASE + 4 * rnd_bits(5));
      skip = 1 + int'(rnd_bits(2) % 3);
      // forward only, never past the register dump.
      if (i + 1 + skip > BODY_LEN) skip = BODY_LEN - i - 1;
      case (kind)
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: ins = {6'h00, rs, rt, rd, 5'd0, FUNCTS[kind]};
        4'd8:    ins = {6'h0d, rs, rt, imm};
        4'd9:    ins = {6'h0f, 5'd0, rt, imm};
        4'd10:   ins = {6'h23, 5'd0, rt, dimm};
        4'd11:   ins = {6'h2b, 5'd0, rt, dimm};
        4'd12:   ins = {6'h04, rs, rt, 16'(skip)};
        4'd13:   ins = {6'h05, rs, rt, 16'(skip)};
        4'd14:   ins = {6'h02, 26'(BASE_IDX + i + 1 + skip)};
        default: ins = {6'h09, rs, rt, imm};
      endcase
      mem[BASE_IDX + i] = ins;
    end
    for (int r = 1; r < 8; r++) begin
      mem[BASE_IDX + BODY_LEN + r - 1] = {6'h2b, 5'd0, 5'(r), 16'(DUMP_BASE + 4 * r)};
    end
    mem[BASE_IDX + BODY_LEN + 7] = {6'h3f, 26'd0};
  endtask

  // reference execution, no delay slot.
  task automatic run_model();
    logic [31:0] r [32];
    logic [31:0] pc, ins, npc, sext, ea;
    logic [4:0]  rs, rt, rd;
    int          steps;
    for (int k = 0; k < 32; k++) r[k] = '0;
    for (int a = 0; a < MEM_WORDS; a++) model_mem[a] = mem[a];
    pc    = `PC_INIT;
    ins   = '0;
    steps = 0;
    while (ins[31:26] != 6'h3f && steps < MAX_INSTR) begin
      ins  = model_mem[pc[9:2]];
      rs   = ins[25:21];
      rt   = ins[20:16];
      rd   = ins[15:11];
      sext = {{16{ins[15]}}, ins[15:0]};
      ea   = r[rs] + sext;
      npc  = pc + 32'd4;
      case (ins[31:26])
        6'h00: begin
          case (ins[5:0])
            6'h21: r[rd] = r[rs] + r[rt];
            6'h23: r[rd] = r[rs] - r[rt];
            6'h24: r[rd] = r[rs] & r[rt];
            6'h25: r[rd] = r[rs] | r[rt];
            6'h26: r[rd] = r[rs] ^ r[rt];
            6'h2a: r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        6'h09: r[rt] = r[rs] + sext;
        6'h0d: r[rt] = r[rs] | {16'h0000, ins[15:0]};
        6'h0f: r[rt] = {ins[15:0], 16'h0000};
        6'h23: r[rt] = model_mem[ea[9:2]];
        6'h2b: begin
          model_mem[ea[9:2]] = r[rt];
          st_addr_q.push_back(ea);
          st_data_q.push_back(r[rt]);
        end
        6'h04: if (r[rs] == r[rt]) npc = pc + 32'd4 + {sext[29:0], 2'b00};
        6'h05: if (r[rs] != r[rt]) npc = pc + 32'd4 + {sext[29:0], 2'b00};
        6'h02: npc = {npc[31:28], ins[25:0], 2'b00};
        default: ;
      endcase
      r[0]  = '0;
      pc    = npc;
      steps = steps + 1;
    end
  endtask

  task automatic check_store();
    logic [31:0] exp_a, exp_d;
    if (st_addr_q.size() == 0) begin
      report_text(T_ST, "store on the memory port with none left in the model");
    end else begin
      exp_a = st_addr_q.pop_front();
      exp_d = st_data_q.pop_front();
      if (mem_addr !== exp_a) report_value(T_ST, exp_a, mem_addr);
      if (mem_wdata !== exp_d) report_value(T_ST, exp_d, mem_wdata);
    end
    stores_seen++;
  endtask

  // memory responder and port monitor, on the falling edge.
  always @(negedge CLK) begin
    if (!nRST) begin
      if (mem_req || halt) report_text(T_RST, "mem_req or halt high during reset");
    end else begin
      if (mem_req && !prev_req && mem_ack) begin
        report_text(T_HS, "request raised while ack still high");
      end
      if (mem_req && prev_req && mem_addr !== held_addr) begin
        report_value(T_HS, held_addr, mem_addr);
      end
      if (mem_req && prev_req && mem_wdata !== held_wdata) begin
        report_value(T_HS, held_wdata, mem_wdata);
      end
      if (mem_req && !prev_req) begin
        if (!first_req_seen && (mem_addr !== `PC_INIT || mem_wen)) begin
          report_value(T_RST, `PC_INIT, mem_addr);
        end
        if (halt_seen) report_text(T_HALT, "memory request after halt");
        first_req_seen = 1'b1;
        held_addr      = mem_addr;
        held_wdata     = mem_wdata;
        ack_delay      = int'(rnd_bits(2));
        pending        = 1'b1;
      end
      if (pending) begin
        if (ack_delay == 0) begin
          pending = 1'b0;
          mem_ack = 1'b1;
          if (mem_wen) begin
            check_store();
            mem[mem_addr[9:2]] = mem_wdata;
          end else begin
            mem_rdata = mem[mem_addr[9:2]];
          end
        end else begin
          ack_delay--;
        end
      end else if (mem_ack && !mem_req) begin
        // ack falls one full cycle after req.
        if (released) begin
          mem_ack  = 1'b0;
          released = 1'b0;
        end else begin
          released = 1'b1;
        end
      end
      if (halt && !halt_seen) begin
        halt_seen = 1'b1;
        if (stores_seen != model_stores) report_value(T_HALT, model_stores, stores_seen);
      end
      if (halt_seen && !halt) report_text(T_HALT, "halt dropped after rising");
      prev_req = mem_req;
    end
  end

  initial begin
    nRST = 1'b0;
    gen_program();
    run_model();
    model_stores = st_addr_q.size();
    repeat (2) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    if (mem_req || halt) report_text(T_RST, "mem_req or halt high right after reset");
    while (!halt_seen && cycles < CYCLE_LIMIT) @(negedge CLK);
    if (!halt_seen) begin
      $display("timeout, halt not seen within %0d cycles", CYCLE_LIMIT);
      errors[T_HALT]++;
    end else begin
      // keep watching the port while halted.
      repeat (20) @(negedge CLK);
      if (st_addr_q.size() != 0) report_value(T_ST, model_stores, stores_seen);
      for (int a = 0; a < MEM_WORDS; a++) begin
        if (mem[a] !== model_mem[a]) report_value(T_MEM, model_mem[a], mem[a]);
      end
    end
    if (!first_req_seen) report_text(T_RST, "no memory request seen");
    passed = 0;
    for (int t = 0; t < 5; t++) begin
      $display("%-24s %s, %0d errors", names[t], (errors[t] == 0) ? "ok" : "failed", errors[t]);
      if (errors[t] == 0) passed++;
    end
    $display("tests: %0d passed, %0d failed", passed, 5 - passed);
    if (passed == 5) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
